//--- source/bpu_pkg.sv
// ==================================================
// Package with table sizes, address and index types
// and the saturating counter limits of the BPU
// ==================================================

`default_nettype none

package bpu_pkg;

    // ==================================================
    // Address layout
    // ==================================================

    // Width of a fetch or resolve address
    localparam int ADDR_WIDTH = 32;

    // Bits 1 and 0 are never looked at, every index starts at bit 2
    localparam int ADDR_LSB = 2;

    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // ==================================================
    // Gshare pattern history table
    // ==================================================

    localparam int PHT_ENTRIES     = 1024;
    localparam int PHT_INDEX_WIDTH = 10;

    // Used both for the global history and the hashed table index
    typedef logic [PHT_INDEX_WIDTH-1:0] pht_index_t;

    // Two bit saturating direction counter, upper bit is the prediction
    typedef logic [1:0] counter_t;

    localparam counter_t COUNTER_RESET = 2'b00;
    localparam counter_t COUNTER_MIN   = 2'b00;
    localparam counter_t COUNTER_MAX   = 2'b11;

    // Target buffer geometry, the tag is everything above the index
    localparam int BTB_ENTRIES     = 64;
    localparam int BTB_INDEX_WIDTH = 6;
    localparam int BTB_TAG_WIDTH   = ADDR_WIDTH - BTB_INDEX_WIDTH - ADDR_LSB;

    typedef logic [BTB_INDEX_WIDTH-1:0] btb_index_t;
    typedef logic [BTB_TAG_WIDTH-1:0]   btb_tag_t;

    // In-order queue of outstanding conditional predictions
    localparam int QUEUE_DEPTH = 4;

    typedef logic [1:0] queue_ptr_t;

endpackage : bpu_pkg

`default_nettype wire

//--- source/branch_target_buffer.sv
// ==================================================
// Direct-mapped tagged branch target buffer
// ==================================================

`timescale 1ns/1ns
`default_nettype none

module branch_target_buffer (
    input  wire logic           clk_i,
    input  wire logic           rst_n_i,

    // Fetch side lookup
    input  wire bpu_pkg::addr_t lookup_pc_i,
    output logic                hit_o,
    output logic                conditional_o,
    output bpu_pkg::addr_t      target_o,

    // Allocation from the execute stage on taken branches
    input  wire logic           update_i,
    input  wire bpu_pkg::addr_t update_pc_i,
    input  wire logic           update_conditional_i,
    input  wire bpu_pkg::addr_t update_target_i
);

    import bpu_pkg::*;

    // ==================================================
    // Storage
    // ==================================================

    // Payload arrays, one slot per index
    btb_tag_t tag_mem    [BTB_ENTRIES];
    addr_t    target_mem [BTB_ENTRIES];
    logic     cond_mem   [BTB_ENTRIES];

    // Only the valid bits are under reset
    logic [BTB_ENTRIES-1:0] valid_q;

    // Arrays start out cleared so lookups never read X
    initial begin
        for (int i = 0; i < BTB_ENTRIES; i++) begin
            tag_mem[i]    = '0;
            target_mem[i] = '0;
            cond_mem[i]   = 1'b0;
        end
    end

    // ==================================================
    // Lookup
    // ==================================================

    btb_index_t lookup_index;
    btb_tag_t   lookup_tag;

    // Index sits just above the ignored byte offset, the tag above that
    assign lookup_index = lookup_pc_i[BTB_INDEX_WIDTH+ADDR_LSB-1:ADDR_LSB];
    assign lookup_tag   = lookup_pc_i[ADDR_WIDTH-1:BTB_INDEX_WIDTH+ADDR_LSB];

    // A hit needs both a valid slot and a matching tag
    assign hit_o = valid_q[lookup_index] && (tag_mem[lookup_index] == lookup_tag);

    // Type and target come straight from the slot, qualified by hit_o upstream
    assign conditional_o = cond_mem[lookup_index];
    assign target_o      = target_mem[lookup_index];

    // ==================================================
    // Allocation
    // ==================================================

    btb_index_t update_index;
    btb_tag_t   update_tag;

    assign update_index = update_pc_i[BTB_INDEX_WIDTH+ADDR_LSB-1:ADDR_LSB];
    assign update_tag   = update_pc_i[ADDR_WIDTH-1:BTB_INDEX_WIDTH+ADDR_LSB];

    // The slot is simply overwritten, a conflicting branch at the same
    // index evicts whatever lived there before
    always_ff @(posedge clk_i) begin
        if (update_i) begin
            tag_mem[update_index]    <= update_tag;
            target_mem[update_index] <= update_target_i;
            cond_mem[update_index]   <= update_conditional_i;
        end
    end

    // Valid bits are set on allocation and only cleared by reset
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (update_i) begin
            valid_q[update_index] <= 1'b1;
        end
    end

    // A lookup and an update in the same cycle see the old slot contents,
    // the new entry becomes visible after the edge

endmodule : branch_target_buffer

`default_nettype wire

//--- source/gshare_predictor.sv
// ==================================================
// Gshare direction predictor with global history,
// counter table, prediction queue and mispredict check
// ==================================================

`timescale 1ns/1ns
`default_nettype none

module gshare_predictor (
    input  wire logic           clk_i,
    input  wire logic           rst_n_i,

    // Fetch side, predict_i is a conditional hit in the target buffer
    input  wire logic           predict_i,
    input  wire bpu_pkg::addr_t lookup_pc_i,
    output logic                prediction_o,
    output logic                accepted_o,
    output logic                busy_o,

    // Resolve side, executed_i marks a resolved conditional branch
    input  wire logic           executed_i,
    input  wire logic           taken_i,
    output logic                mispredicted_o
);

    import bpu_pkg::*;

    // Occupancy needs one more bit than the pointers to tell full from empty
    typedef logic [$clog2(QUEUE_DEPTH+1)-1:0] count_t;

    localparam count_t QUEUE_FULL = count_t'(QUEUE_DEPTH);

    // ==================================================
    // Global history and hashed index
    // ==================================================

    pht_index_t history_q;
    pht_index_t hashed_index;

    // Address bits 11 down to 2 folded with the most recent outcomes
    assign hashed_index = history_q ^ lookup_pc_i[PHT_INDEX_WIDTH+ADDR_LSB-1:ADDR_LSB];

    // Every resolved conditional shifts its outcome in at bit 0,
    // whether or not it had a queued prediction
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            history_q <= '0;
        end else if (executed_i) begin
            history_q <= {history_q[PHT_INDEX_WIDTH-2:0], taken_i};
        end
    end

    // ==================================================
    // Prediction queue
    // ==================================================

    logic       queue_pred_q  [QUEUE_DEPTH];
    pht_index_t queue_index_q [QUEUE_DEPTH];

    queue_ptr_t push_ptr_q;
    queue_ptr_t pull_ptr_q;
    count_t     count_q;

    logic queue_full;
    logic queue_empty;
    logic push;
    logic pull;

    assign queue_full  = (count_q == QUEUE_FULL);
    assign queue_empty = (count_q == '0);

    // A full queue refuses new predictions even when a pull frees a slot
    // in the same cycle, so busy drops one cycle after the first pull
    assign push = predict_i && !queue_full;
    assign pull = executed_i && !queue_empty;

    assign accepted_o = push;
    assign busy_o     = queue_full;

    // Prediction bit and table index travel together to the resolve side
    always_ff @(posedge clk_i) begin
        if (push) begin
            queue_pred_q[push_ptr_q]  <= prediction_o;
            queue_index_q[push_ptr_q] <= hashed_index;
        end
    end

    // Pointers wrap naturally at the queue depth
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            push_ptr_q <= '0;
            pull_ptr_q <= '0;
            count_q    <= '0;
        end else begin
            if (push) begin
                push_ptr_q <= queue_ptr_t'(push_ptr_q + 1'b1);
            end
            if (pull) begin
                pull_ptr_q <= queue_ptr_t'(pull_ptr_q + 1'b1);
            end
            case ({push, pull})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // ==================================================
    // Counter table and training
    // ==================================================

    counter_t   pht_mem [PHT_ENTRIES];
    counter_t   head_counter;
    counter_t   trained_counter;
    pht_index_t head_index;
    logic       head_pred;

    initial begin
        for (int i = 0; i < PHT_ENTRIES; i++) begin
            pht_mem[i] = COUNTER_RESET;
        end
    end

    // Oldest outstanding prediction
    assign head_index = queue_index_q[pull_ptr_q];
    assign head_pred  = queue_pred_q[pull_ptr_q];

    // Two read ports, one for fetch and one for the counter being trained
    assign prediction_o = pht_mem[hashed_index][1];
    assign head_counter = pht_mem[head_index];

    // saturate at both ends
    always_comb begin
        if (taken_i) begin
            trained_counter = (head_counter == COUNTER_MAX) ? head_counter
                                                            : head_counter + 1'b1;
        end else begin
            trained_counter = (head_counter == COUNTER_MIN) ? head_counter
                                                            : head_counter - 1'b1;
        end
    end

    // Counters change only when a queued entry is pulled, a fetch in the
    // same cycle still reads the old value
    always_ff @(posedge clk_i) begin
        if (pull) begin
            pht_mem[head_index] <= trained_counter;
        end
    end

    // Outcome against the direction that was handed to fetch
    assign mispredicted_o = pull && (taken_i != head_pred);

endmodule : gshare_predictor

`default_nettype wire

//--- source/branch_prediction_unit.sv
// ==================================================
// BPU top joining the target buffer and the gshare
// predictor into fetch and resolve interfaces
// ==================================================

`timescale 1ns/1ns
`default_nettype none

module branch_prediction_unit (
    input  wire logic           clk_i,
    input  wire logic           rst_n_i,

    // Fetch stage
    input  wire logic           fetch_valid_i,
    input  wire bpu_pkg::addr_t fetch_pc_i,
    output logic                pred_valid_o,
    output logic                pred_taken_o,
    output bpu_pkg::addr_t      pred_target_o,
    output logic                bpu_busy_o,

    // Execute stage
    input  wire logic           resolve_valid_i,
    input  wire bpu_pkg::addr_t resolve_pc_i,
    input  wire logic           resolve_conditional_i,
    input  wire logic           resolve_taken_i,
    input  wire bpu_pkg::addr_t resolve_target_i,
    output logic                mispredict_o
);

    import bpu_pkg::*;

    logic  btb_hit;
    logic  btb_conditional;
    addr_t btb_target;
    logic  fetch_hit;
    logic  predict;
    logic  gshare_prediction;
    logic  gshare_accepted;
    logic  executed;
    logic  allocate;

    // Lookups only count while fetch presents a valid address
    assign fetch_hit = fetch_valid_i && btb_hit;
    assign predict   = fetch_hit && btb_conditional;

    // Only conditional resolves train the predictor, any taken branch allocates
    assign executed = resolve_valid_i && resolve_conditional_i;
    assign allocate = resolve_valid_i && resolve_taken_i;

    branch_target_buffer u_btb (
        .clk_i                (clk_i),
        .rst_n_i              (rst_n_i),
        .lookup_pc_i          (fetch_pc_i),
        .hit_o                (btb_hit),
        .conditional_o        (btb_conditional),
        .target_o             (btb_target),
        .update_i             (allocate),
        .update_pc_i          (resolve_pc_i),
        .update_conditional_i (resolve_conditional_i),
        .update_target_i      (resolve_target_i)
    );

    gshare_predictor u_gshare (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .predict_i      (predict),
        .lookup_pc_i    (fetch_pc_i),
        .prediction_o   (gshare_prediction),
        .accepted_o     (gshare_accepted),
        .busy_o         (bpu_busy_o),
        .executed_i     (executed),
        .taken_i        (resolve_taken_i),
        .mispredicted_o (mispredict_o)
    );

    // A conditional hit is only valid when its prediction got a queue slot
    assign pred_valid_o  = fetch_hit && (!btb_conditional || gshare_accepted);
    assign pred_taken_o  = fetch_hit && (!btb_conditional || gshare_prediction);
    assign pred_target_o = btb_target;

endmodule : branch_prediction_unit

`default_nettype wire

//--- testbench/bpu_ref_model.sv
// ==================================================
// Behavioral model of target buffer, history, counters
// and prediction queue for expected BPU outputs
// ==================================================

`timescale 1ns/1ns
`default_nettype none

module bpu_ref_model (
    input  wire logic           clk_i,
    input  wire logic           rst_n_i,
    input  wire logic           fetch_valid_i,
    input  wire bpu_pkg::addr_t fetch_pc_i,
    input  wire logic           resolve_valid_i,
    input  wire bpu_pkg::addr_t resolve_pc_i,
    input  wire logic           resolve_conditional_i,
    input  wire logic           resolve_taken_i,
    input  wire bpu_pkg::addr_t resolve_target_i,
    output logic                exp_valid_o,
    output logic                exp_taken_o,
    output bpu_pkg::addr_t      exp_target_o,
    output logic                exp_busy_o,
    output logic                exp_mispredict_o
);

    import bpu_pkg::*;

    // Buffer entries keep the whole branch address, a hit compares bits 31 to 2
    logic [BTB_ENTRIES-1:0] btb_valid;
    addr_t                  btb_pc     [BTB_ENTRIES];
    addr_t                  btb_target [BTB_ENTRIES];
    logic                   btb_cond   [BTB_ENTRIES];

    counter_t   pht [PHT_ENTRIES];
    pht_index_t history;

    // Each queued entry is {predicted direction, counter index}
    logic [PHT_INDEX_WIDTH:0] pending [$];
    logic [PHT_INDEX_WIDTH:0] oldest;
    logic [PHT_INDEX_WIDTH:0] head;
    pht_index_t               trained;
    int                       depth = 0;
    logic                     head_pred = 1'b0;

    btb_index_t fetch_slot;
    btb_index_t resolve_slot;
    pht_index_t hashed;
    logic       hit;
    logic       cond;
    logic       direction;

    // Every counter starts out strongly not taken
    initial begin
        for (int i = 0; i < PHT_ENTRIES; i++) begin
            pht[i] = COUNTER_RESET;
        end
    end

    // ==================================================
    // Same-cycle fetch and resolve responses
    // ==================================================

    always_comb begin
        fetch_slot = fetch_pc_i[7:2];
        hashed     = fetch_pc_i[11:2] ^ history;
        hit        = fetch_valid_i && btb_valid[fetch_slot]
                     && (btb_pc[fetch_slot][31:2] == fetch_pc_i[31:2]);
        cond       = btb_cond[fetch_slot];
        direction  = pht[hashed][1];
        // A conditional hit only counts when the queue still has room
        exp_valid_o      = hit && (!cond || depth < QUEUE_DEPTH);
        exp_taken_o      = hit && (!cond || direction);
        exp_target_o     = btb_target[fetch_slot];
        exp_busy_o       = (depth == QUEUE_DEPTH);
        exp_mispredict_o = resolve_valid_i && resolve_conditional_i && depth > 0
                           && (resolve_taken_i != head_pred);
    end

    // ==================================================
    // State update at the rising edge
    // ==================================================

    always @(posedge clk_i) begin
        resolve_slot = resolve_pc_i[7:2];
        if (!rst_n_i) begin
            btb_valid = '0;
            history   = '0;
            pending.delete();
        end else begin
            // The pull decision uses the occupancy from before this push
            if (hit && cond && depth < QUEUE_DEPTH) begin
                pending.push_back({direction, hashed});
            end
            if (resolve_valid_i && resolve_conditional_i) begin
                if (depth > 0) begin
                    oldest  = pending.pop_front();
                    trained = oldest[PHT_INDEX_WIDTH-1:0];
                    if (resolve_taken_i && pht[trained] != 2'b11) begin
                        pht[trained] = pht[trained] + 2'd1;
                    end else if (!resolve_taken_i && pht[trained] != 2'b00) begin
                        pht[trained] = pht[trained] - 2'd1;
                    end
                end
                history = {history[PHT_INDEX_WIDTH-2:0], resolve_taken_i};
            end
            // Any taken branch claims its slot, evicting an older owner
            if (resolve_valid_i && resolve_taken_i) begin
                btb_valid[resolve_slot]  = 1'b1;
                btb_pc[resolve_slot]     = resolve_pc_i;
                btb_target[resolve_slot] = resolve_target_i;
                btb_cond[resolve_slot]   = resolve_conditional_i;
            end
        end
        depth = pending.size();
        if (depth > 0) begin
            head      = pending[0];
            head_pred = head[PHT_INDEX_WIDTH];
        end else begin
            head_pred = 1'b0;
        end
    end

endmodule : bpu_ref_model

`default_nettype wire

//--- testbench/tb_branch_prediction_unit.sv
// ==================================================
// Testbench for the BPU with directed and random
// stimulus checked against the reference model
// ==================================================

`timescale 1ns/1ns
`default_nettype none

module tb_branch_prediction_unit;

    import bpu_pkg::*;

    logic  clk_i;
    logic  rst_n_i;
    logic  fetch_valid_i;
    addr_t fetch_pc_i;
    logic  pred_valid_o;
    logic  pred_taken_o;
    addr_t pred_target_o;
    logic  bpu_busy_o;
    logic  resolve_valid_i;
    addr_t resolve_pc_i;
    logic  resolve_conditional_i;
    logic  resolve_taken_i;
    addr_t resolve_target_i;
    logic  mispredict_o;

    logic  exp_valid;
    logic  exp_taken;
    addr_t exp_target;
    logic  exp_busy;
    logic  exp_mispredict;

    // Entries 0 to 3 are only ever resolved as conditional branches
    addr_t  pool [6];
    addr_t  inflight [$];
    integer seed;

    branch_prediction_unit u_branch_prediction_unit (
        .clk_i                 (clk_i),
        .rst_n_i               (rst_n_i),
        .fetch_valid_i         (fetch_valid_i),
        .fetch_pc_i            (fetch_pc_i),
        .pred_valid_o          (pred_valid_o),
        .pred_taken_o          (pred_taken_o),
        .pred_target_o         (pred_target_o),
        .bpu_busy_o            (bpu_busy_o),
        .resolve_valid_i       (resolve_valid_i),
        .resolve_pc_i          (resolve_pc_i),
        .resolve_conditional_i (resolve_conditional_i),
        .resolve_taken_i       (resolve_taken_i),
        .resolve_target_i      (resolve_target_i),
        .mispredict_o          (mispredict_o)
    );

    bpu_ref_model u_model (
        .clk_i                 (clk_i),
        .rst_n_i               (rst_n_i),
        .fetch_valid_i         (fetch_valid_i),
        .fetch_pc_i            (fetch_pc_i),
        .resolve_valid_i       (resolve_valid_i),
        .resolve_pc_i          (resolve_pc_i),
        .resolve_conditional_i (resolve_conditional_i),
        .resolve_taken_i       (resolve_taken_i),
        .resolve_target_i      (resolve_target_i),
        .exp_valid_o           (exp_valid),
        .exp_taken_o           (exp_taken),
        .exp_target_o          (exp_target),
        .exp_busy_o            (exp_busy),
        .exp_mispredict_o      (exp_mispredict)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // ==================================================
    // Failure reporting and stimulus helpers
    // ==================================================

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        abort_run($sformatf("mismatch %s: got %h expected %h", name, got, want));
    endtask

    function automatic logic is_conditional_pc(input addr_t pc);
        return (pc == pool[0]) || (pc == pool[1]) || (pc == pool[2]) || (pc == pool[3]);
    endfunction

    // One cycle of fetch and resolve strobes, applied at the rising edge
    task automatic drive_cycle(input logic fv, input addr_t fpc, input logic rv,
                               input addr_t rpc, input logic rc, input logic rt,
                               input addr_t rtgt);
        @(posedge clk_i);
        fetch_valid_i         <= fv;
        fetch_pc_i            <= fpc;
        resolve_valid_i       <= rv;
        resolve_pc_i          <= rpc;
        resolve_conditional_i <= rc;
        resolve_taken_i       <= rt;
        resolve_target_i      <= rtgt;
    endtask

    task automatic fetch_only(input addr_t pc);
        drive_cycle(1'b1, pc, 1'b0, '0, 1'b0, 1'b0, '0);
    endtask

    task automatic resolve_only(input addr_t pc, input logic cond, input logic taken,
                                input addr_t target);
        drive_cycle(1'b0, '0, 1'b1, pc, cond, taken, target);
    endtask

    // Shifts a known pattern into the history, oldest bit first
    // With the queue empty these resolves move no counter
    task automatic load_history(input pht_index_t pattern);
        for (int b = PHT_INDEX_WIDTH - 1; b >= 0; b--) begin
            resolve_only(pool[0], 1'b1, pattern[b], 32'h0000_2400);
        end
    endtask

    // Moves the counter that pc selects under the given history one step
    task automatic train_counter(input pht_index_t pattern, input addr_t pc,
                                 input logic taken);
        load_history(pattern);
        fetch_only(pc);
        resolve_only(pc, 1'b1, taken, 32'h0000_2400);
    endtask

    // Polls busy at falling edges, where the outputs have settled
    task automatic wait_busy_level(input logic level);
        int cycles;
        cycles = 0;
        @(negedge clk_i);
        while (bpu_busy_o !== level) begin
            cycles++;
            if (cycles > 16) begin
                abort_run("timeout while waiting for bpu_busy_o to change");
            end
            @(negedge clk_i);
        end
    endtask

    // ==================================================
    // Per-cycle comparison with the model
    // ==================================================

    always @(negedge clk_i) begin
        if (rst_n_i) begin
            assert (pred_valid_o === exp_valid)
                else report_mismatch("pred_valid_o", 32'(pred_valid_o), 32'(exp_valid));
            assert (pred_taken_o === exp_taken)
                else report_mismatch("pred_taken_o", 32'(pred_taken_o), 32'(exp_taken));
            if (exp_valid) begin
                assert (pred_target_o === exp_target)
                    else report_mismatch("pred_target_o", pred_target_o, exp_target);
            end
            assert (bpu_busy_o === exp_busy)
                else report_mismatch("bpu_busy_o", 32'(bpu_busy_o), 32'(exp_busy));
            assert (mispredict_o === exp_mispredict)
                else report_mismatch("mispredict_o", 32'(mispredict_o), 32'(exp_mispredict));
            // Queued conditional fetches, oldest first, for in-order resolves
            if (fetch_valid_i && pred_valid_o && is_conditional_pc(fetch_pc_i)) begin
                inflight.push_back(fetch_pc_i);
            end
        end
    end

    // ==================================================
    // Stimulus
    // ==================================================

    initial begin
        logic [31:0] r;
        int          k;
        int          j;
        logic        rv;
        logic        rc;
        logic        rt;
        addr_t       rpc;

        seed    = 32'hc7a1_47ae;
        pool[0] = 32'h0000_2000;
        pool[1] = 32'h0000_2004;
        pool[2] = 32'h0000_2108;
        pool[3] = 32'h0000_230c;
        pool[4] = 32'h0001_0040;
        pool[5] = 32'h0000_3054;
        rst_n_i               = 1'b0;
        fetch_valid_i         = 1'b0;
        fetch_pc_i            = '0;
        resolve_valid_i       = 1'b0;
        resolve_pc_i          = '0;
        resolve_conditional_i = 1'b0;
        resolve_taken_i       = 1'b0;
        resolve_target_i      = '0;
        repeat (8) @(posedge clk_i);
        rst_n_i <= 1'b1;

        // Empty buffer, every fetch misses
        fetch_only(32'h1234_5678);
        fetch_only(pool[0]);

        // Jump allocation, then eviction by a branch at the same index
        resolve_only(32'h0000_0040, 1'b0, 1'b1, 32'h0000_8000);
        fetch_only(32'h0000_0040);
        @(negedge clk_i);
        assert (pred_valid_o && pred_taken_o)
            else abort_run("allocated jump at 0x40 was not predicted taken");
        resolve_only(pool[4], 1'b0, 1'b1, 32'h0000_9000);
        fetch_only(32'h0000_0040);
        fetch_only(pool[4]);

        // Repeated training of one conditional branch
        resolve_only(pool[0], 1'b1, 1'b1, 32'h0000_2400);
        for (int i = 0; i < 20; i++) begin
            fetch_only(pool[0]);
            resolve_only(pool[0], 1'b1, logic'(i < 14), 32'h0000_2400);
        end

        // Same address under changing history
        for (int h = 0; h < 8; h++) begin
            resolve_only(pool[1], 1'b1, h[0], 32'h0000_2500);
            fetch_only(pool[0]);
            resolve_only(pool[0], 1'b1, h[1], 32'h0000_2400);
        end

        // Under one fixed history bias the first counter taken, its neighbour not taken
        for (int n = 0; n < 2; n++) begin
            train_counter(10'h155, pool[0], 1'b1);
            train_counter(10'h155, pool[1], 1'b0);
        end
        load_history(10'h155);

        // Alternating addresses queue taken, not taken, taken, not taken
        // The fifth fetch finds the queue full and is refused
        for (int n = 0; n < 5; n++) begin
            fetch_only(pool[n % 2]);
        end
        wait_busy_level(1'b1);
        drive_cycle(1'b1, pool[0], 1'b1, pool[0], 1'b1, 1'b1, 32'h0000_2400);
        drive_cycle(1'b0, '0, 1'b0, '0, 1'b0, 1'b0, '0);
        wait_busy_level(1'b0);

        // Only the third queued entry disagrees with a not taken outcome
        for (int n = 1; n < 4; n++) begin
            resolve_only(pool[n % 2], 1'b1, 1'b0, 32'h0000_2400);
        end
        inflight.delete();

        // Random mix, resolves follow the queued fetches when there are any
        for (int i = 0; i < 400; i++) begin
            r   = $random(seed);
            k   = int'(r[3:1]) % 6;
            rv  = 1'b0;
            rc  = 1'b0;
            rt  = 1'b0;
            rpc = '0;
            if (r[6:4] < 3'd3) begin
                rv = 1'b1;
                if (inflight.size() > 0) begin
                    rpc = inflight.pop_front();
                    rc  = 1'b1;
                    rt  = r[11];
                end else begin
                    j   = int'(r[10:8]) % 6;
                    rpc = pool[j];
                    rc  = (j < 4);
                    rt  = r[11] || !rc;
                end
            end
            drive_cycle(r[0], pool[k], rv, rpc, rc, rt, {8'h00, r[31:10], 2'b00});
        end
        drive_cycle(1'b0, '0, 1'b0, '0, 1'b0, 1'b0, '0);
        @(negedge clk_i);

        $display("No errors");
        $finish;
    end

endmodule : tb_branch_prediction_unit

`default_nettype wire

//--- files.f
source/bpu_pkg.sv
source/branch_target_buffer.sv
source/gshare_predictor.sv
source/branch_prediction_unit.sv
testbench/bpu_ref_model.sv
testbench/tb_branch_prediction_unit.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert --timescale 1ns/1ns -j 0
TOP       ?= tb_branch_prediction_unit
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir

SOURCES := $(shell grep -v '^+' $(FILELIST))
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BINARY)

clean:
	rm -rf $(BUILD_DIR)
